//--- la_decode_pkg.sv
package la_decode_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  exc_cause_t;

    localparam exc_cause_t EXC_INE = 6'h0d; // instruction not exist.
    localparam csr_addr_t  CSR_TID = 14'h040;

    // inst[31:10].
    localparam logic [21:0] ERTN_OPCODE     = 22'h01920e;
    localparam logic [21:0] RDCNTID_OPCODE  = 22'h000018; // also rdcntvl.w.
    localparam logic [21:0] RDCNTVHW_OPCODE = 22'h000019;
    localparam logic [21:0] TLBSRCH_OPCODE  = 22'h01920a;
    localparam logic [21:0] TLBRD_OPCODE    = 22'h01920b;
    localparam logic [21:0] TLBWR_OPCODE    = 22'h01920c;
    localparam logic [21:0] TLBFILL_OPCODE  = 22'h01920d;

    // inst[31:15].
    localparam logic [16:0] ADD_W_OPCODE = 17'h00020;
    localparam logic [16:0] SUB_W_OPCODE = 17'h00022;
    localparam logic [16:0] AND_OPCODE   = 17'h00029;
    localparam logic [16:0] OR_OPCODE    = 17'h0002a;

    // inst[31:22].
    localparam logic [9:0] ADDI_W_OPCODE = 10'h00a;
    localparam logic [9:0] LD_W_OPCODE   = 10'h0a2;
    localparam logic [9:0] ST_W_OPCODE   = 10'h0a6;

    localparam logic [7:0] CSR_OPCODE = 8'h04; // inst[31:24].

    typedef enum logic [7:0] {
        ALU_NOP, ALU_ERTN, ALU_RDCNTID, ALU_RDCNTVLW, ALU_RDCNTVHW,
        ALU_TLBSRCH, ALU_TLBRD, ALU_TLBWR, ALU_TLBFILL,
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_LD, ALU_ST,
        ALU_CSRRD, ALU_CSRWR, ALU_CSRXCHG
    } aluop_t;

    typedef enum logic [2:0] {
        ALU_SEL_NOP, ALU_SEL_ARITH, ALU_SEL_LOGIC, ALU_SEL_LOAD_STORE, ALU_SEL_CSR
    } alusel_t;

    typedef struct packed {
        bus32_t          pc;
        bus32_t          inst;
        logic            inst_valid;
        logic            is_privilege;
        logic            is_cnt;
        logic [1:0]      reg_read_en;
        reg_addr_t [1:0] reg_read_addr;
        logic            reg_write_en;
        reg_addr_t       reg_write_addr;
        aluop_t          aluop;
        alusel_t         alusel;
        bus32_t          imm;
        logic            csr_read_en;
        logic            csr_write_en;
        csr_addr_t       csr_addr;
        logic            is_exception;
        exc_cause_t      exception_cause;
    } id_dispatch_t;

endpackage

//--- decoder_1r.sv
module decoder_1r (
    input  la_decode_pkg::bus32_t       pc_i,
    input  la_decode_pkg::bus32_t       inst_i,
    output la_decode_pkg::id_dispatch_t id_o
);

    import la_decode_pkg::*;

    logic [21:0] opcode;
    reg_addr_t   rj;
    reg_addr_t   rd;

    assign opcode = inst_i[31:10];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];

    always_comb begin
        id_o          = '0;
        id_o.pc       = pc_i;
        id_o.inst     = inst_i;
        id_o.aluop    = ALU_NOP;
        id_o.alusel   = ALU_SEL_NOP;
        id_o.csr_addr = CSR_TID; // no csr access unless rdcntid.

        case (opcode)
            ERTN_OPCODE: begin
                id_o.inst_valid   = 1'b1;
                id_o.is_privilege = 1'b1;
                id_o.aluop        = ALU_ERTN;
            end
            RDCNTID_OPCODE: begin
                id_o.inst_valid   = 1'b1;
                id_o.is_cnt       = 1'b1;
                id_o.reg_write_en = 1'b1;
                id_o.alusel       = ALU_SEL_CSR;
                if (rj == 5'd0) begin // rdcntvl.w.
                    id_o.reg_write_addr = rd;
                    id_o.aluop          = ALU_RDCNTVLW;
                end else begin
                    id_o.reg_write_addr = rj;
                    id_o.aluop          = ALU_RDCNTID;
                    id_o.csr_read_en    = 1'b1;
                end
            end
            RDCNTVHW_OPCODE: begin
                id_o.inst_valid     = 1'b1;
                id_o.is_cnt         = 1'b1;
                id_o.reg_write_en   = 1'b1;
                id_o.reg_write_addr = rd;
                id_o.aluop          = ALU_RDCNTVHW;
                id_o.alusel         = ALU_SEL_CSR;
            end
            TLBSRCH_OPCODE, TLBRD_OPCODE, TLBWR_OPCODE, TLBFILL_OPCODE: begin
                id_o.inst_valid   = 1'b1;
                id_o.is_privilege = 1'b1;
                id_o.alusel       = ALU_SEL_CSR;
                case (opcode[1:0]) // low bits tell the tlb ops apart.
                    2'b10:   id_o.aluop = ALU_TLBSRCH;
                    2'b11:   id_o.aluop = ALU_TLBRD;
                    2'b00:   id_o.aluop = ALU_TLBWR;
                    default: id_o.aluop = ALU_TLBFILL;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- decoder_3r.sv
module decoder_3r (
    input  la_decode_pkg::bus32_t       pc_i,
    input  la_decode_pkg::bus32_t       inst_i,
    output la_decode_pkg::id_dispatch_t id_o
);

    import la_decode_pkg::*;

    logic [16:0] opcode;
    reg_addr_t   rk;
    reg_addr_t   rj;
    reg_addr_t   rd;
    logic        hit;

    assign opcode = inst_i[31:15];
    assign rk     = inst_i[14:10];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];

    assign hit = (opcode == ADD_W_OPCODE) || (opcode == SUB_W_OPCODE) ||
                 (opcode == AND_OPCODE)   || (opcode == OR_OPCODE);

    always_comb begin
        id_o          = '0;
        id_o.pc       = pc_i;
        id_o.inst     = inst_i;
        id_o.aluop    = ALU_NOP;
        id_o.alusel   = ALU_SEL_NOP;
        id_o.csr_addr = CSR_TID;

        if (hit) begin
            id_o.inst_valid       = 1'b1;
            id_o.reg_read_en      = 2'b11;
            id_o.reg_read_addr[0] = rj;
            id_o.reg_read_addr[1] = rk;
            id_o.reg_write_en     = 1'b1;
            id_o.reg_write_addr   = rd;
        end

        case (opcode)
            ADD_W_OPCODE: begin
                id_o.aluop  = ALU_ADD;
                id_o.alusel = ALU_SEL_ARITH;
            end
            SUB_W_OPCODE: begin
                id_o.aluop  = ALU_SUB;
                id_o.alusel = ALU_SEL_ARITH;
            end
            AND_OPCODE: begin
                id_o.aluop  = ALU_AND;
                id_o.alusel = ALU_SEL_LOGIC;
            end
            OR_OPCODE: begin
                id_o.aluop  = ALU_OR;
                id_o.alusel = ALU_SEL_LOGIC;
            end
            default: ;
        endcase
    end

endmodule

//--- decoder_2ri12.sv
module decoder_2ri12 (
    input  la_decode_pkg::bus32_t       pc_i,
    input  la_decode_pkg::bus32_t       inst_i,
    output la_decode_pkg::id_dispatch_t id_o
);

    import la_decode_pkg::*;

    logic [9:0]  opcode;
    logic [11:0] si12;
    reg_addr_t   rj;
    reg_addr_t   rd;
    bus32_t      imm_sext;

    assign opcode   = inst_i[31:22];
    assign si12     = inst_i[21:10];
    assign rj       = inst_i[9:5];
    assign rd       = inst_i[4:0];
    assign imm_sext = {{20{si12[11]}}, si12};

    always_comb begin
        id_o          = '0;
        id_o.pc       = pc_i;
        id_o.inst     = inst_i;
        id_o.aluop    = ALU_NOP;
        id_o.alusel   = ALU_SEL_NOP;
        id_o.csr_addr = CSR_TID;
        id_o.imm      = imm_sext; // only meaningful when inst_valid.

        case (opcode)
            ADDI_W_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.reg_read_en      = 2'b01;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.aluop            = ALU_ADD;
                id_o.alusel           = ALU_SEL_ARITH;
            end
            LD_W_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.reg_read_en      = 2'b01;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.aluop            = ALU_LD;
                id_o.alusel           = ALU_SEL_LOAD_STORE;
            end
            ST_W_OPCODE: begin
                id_o.inst_valid       = 1'b1;
                id_o.reg_read_en      = 2'b11;
                id_o.reg_read_addr[0] = rj; // base.
                id_o.reg_read_addr[1] = rd; // store data.
                id_o.aluop            = ALU_ST;
                id_o.alusel           = ALU_SEL_LOAD_STORE;
            end
            default: ;
        endcase
    end

endmodule

//--- decoder_csr.sv
module decoder_csr (
    input  la_decode_pkg::bus32_t       pc_i,
    input  la_decode_pkg::bus32_t       inst_i,
    output la_decode_pkg::id_dispatch_t id_o
);

    import la_decode_pkg::*;

    logic [7:0] opcode;
    csr_addr_t  csr_num;
    reg_addr_t  rj;
    reg_addr_t  rd;

    assign opcode  = inst_i[31:24];
    assign csr_num = inst_i[23:10];
    assign rj      = inst_i[9:5];
    assign rd      = inst_i[4:0];

    always_comb begin
        id_o          = '0;
        id_o.pc       = pc_i;
        id_o.inst     = inst_i;
        id_o.aluop    = ALU_NOP;
        id_o.alusel   = ALU_SEL_NOP;
        id_o.csr_addr = CSR_TID;

        if (opcode == CSR_OPCODE) begin
            id_o.inst_valid     = 1'b1;
            id_o.is_privilege   = 1'b1;
            id_o.reg_write_en   = 1'b1; // old csr value goes to rd.
            id_o.reg_write_addr = rd;
            id_o.alusel         = ALU_SEL_CSR;
            id_o.csr_addr       = csr_num;
            id_o.csr_read_en    = 1'b1;

            if (rj == 5'd0) begin
                id_o.aluop = ALU_CSRRD;
            end else if (rj == 5'd1) begin
                id_o.aluop            = ALU_CSRWR;
                id_o.reg_read_en      = 2'b01;
                id_o.reg_read_addr[0] = rd;
                id_o.csr_write_en     = 1'b1;
            end else begin
                // rj holds the write mask.
                id_o.aluop            = ALU_CSRXCHG;
                id_o.reg_read_en      = 2'b11;
                id_o.reg_read_addr[0] = rd;
                id_o.reg_read_addr[1] = rj;
                id_o.csr_write_en     = 1'b1;
            end
        end
    end

endmodule

//--- id_select.sv
module id_select (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  la_decode_pkg::id_dispatch_t rec_1r_i,
    input  la_decode_pkg::id_dispatch_t rec_3r_i,
    input  la_decode_pkg::id_dispatch_t rec_2ri12_i,
    input  la_decode_pkg::id_dispatch_t rec_csr_i,
    output la_decode_pkg::id_dispatch_t id_o
);

    import la_decode_pkg::*;

    logic [3:0] hit;

    assign hit = {rec_csr_i.inst_valid, rec_2ri12_i.inst_valid,
                  rec_3r_i.inst_valid, rec_1r_i.inst_valid};

    always_comb begin
        case (hit)
            4'b0001: id_o = rec_1r_i;
            4'b0010: id_o = rec_3r_i;
            4'b0100: id_o = rec_2ri12_i;
            4'b1000: id_o = rec_csr_i;
            default: begin
                // nobody claimed the word, so raise ine.
                id_o                 = '0;
                id_o.pc              = rec_1r_i.pc;
                id_o.inst            = rec_1r_i.inst;
                id_o.aluop           = ALU_NOP;
                id_o.alusel          = ALU_SEL_NOP;
                id_o.csr_addr        = CSR_TID;
                id_o.is_exception    = 1'b1;
                id_o.exception_cause = EXC_INE;
            end
        endcase
    end

    // opcode spaces of the four decoders must not overlap.
    a_single_claim: assert property (
        @(posedge clk) disable iff (!arst_n_i) $onehot0(hit)
    ) else $error("id_select: %b decoders claimed the same word", hit);

endmodule

//--- id_stage.sv
module id_stage (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        fetch_valid_i,
    input  la_decode_pkg::bus32_t       fetch_pc_i,
    input  la_decode_pkg::bus32_t       fetch_inst_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    output logic                        dispatch_valid_o,
    output la_decode_pkg::id_dispatch_t dispatch_o
);

    import la_decode_pkg::*;

    id_dispatch_t rec_1r;
    id_dispatch_t rec_3r;
    id_dispatch_t rec_2ri12;
    id_dispatch_t rec_csr;
    id_dispatch_t merged;

    decoder_1r    u_dec_1r    (.pc_i(fetch_pc_i), .inst_i(fetch_inst_i), .id_o(rec_1r));
    decoder_3r    u_dec_3r    (.pc_i(fetch_pc_i), .inst_i(fetch_inst_i), .id_o(rec_3r));
    decoder_2ri12 u_dec_2ri12 (.pc_i(fetch_pc_i), .inst_i(fetch_inst_i), .id_o(rec_2ri12));
    decoder_csr   u_dec_csr   (.pc_i(fetch_pc_i), .inst_i(fetch_inst_i), .id_o(rec_csr));

    id_select u_select (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rec_1r_i    (rec_1r),
        .rec_3r_i    (rec_3r),
        .rec_2ri12_i (rec_2ri12),
        .rec_csr_i   (rec_csr),
        .id_o        (merged)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dispatch_valid_o <= 1'b0;
            dispatch_o       <= '0;
        end else if (flush_i) begin
            dispatch_valid_o <= 1'b0; // flush wins over stall.
        end else if (!stall_i) begin
            dispatch_valid_o <= fetch_valid_i;
            if (fetch_valid_i) begin
                dispatch_o <= merged;
            end
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i) !$isunknown(dispatch_valid_o)
    ) else $error("id_stage: dispatch_valid_o is unknown");

endmodule

//--- tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import la_decode_pkg::*;

    localparam int DRAIN_LIMIT = 50;

    logic         clk;
    logic         arst_n_i;
    logic         fetch_valid_i;
    bus32_t       fetch_pc_i;
    bus32_t       fetch_inst_i;
    logic         stall_i;
    logic         flush_i;
    logic         dispatch_valid_o;
    id_dispatch_t dispatch_o;

    id_dispatch_t exp_q[$];
    id_dispatch_t held = '0; // what the output register should hold.
    logic         exp_valid;
    logic         fresh;     // register loaded on the last edge.
    logic         in_reset;
    bus32_t       pc_next;
    integer       seed = 32'h7b13_cb0f;
    string        test_name;
    int           test_errs;
    int           errors;
    int           checks;

    logic [21:0] sys_ops [7] = '{ERTN_OPCODE, RDCNTID_OPCODE, RDCNTVHW_OPCODE, TLBSRCH_OPCODE,
                                 TLBRD_OPCODE, TLBWR_OPCODE, TLBFILL_OPCODE};
    logic [16:0] alu_ops [4] = '{ADD_W_OPCODE, SUB_W_OPCODE, AND_OPCODE, OR_OPCODE};
    logic [9:0]  imm_ops [3] = '{ADDI_W_OPCODE, LD_W_OPCODE, ST_W_OPCODE};

    id_stage u_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bus32_t next_rand();
        return $random(seed);
    endfunction

    function automatic id_dispatch_t ref_decode(input bus32_t pc, input bus32_t inst);
        id_dispatch_t r;
        reg_addr_t    rd;
        reg_addr_t    rj;
        rd           = inst[4:0];
        rj           = inst[9:5];
        r            = '0;
        r.pc         = pc;
        r.inst       = inst;
        r.aluop      = ALU_NOP;
        r.alusel     = ALU_SEL_NOP;
        r.csr_addr   = CSR_TID;
        r.inst_valid = 1'b1;
        case (inst[31:10])
            ERTN_OPCODE:     r.aluop = ALU_ERTN;
            TLBSRCH_OPCODE:  r.aluop = ALU_TLBSRCH;
            TLBRD_OPCODE:    r.aluop = ALU_TLBRD;
            TLBWR_OPCODE:    r.aluop = ALU_TLBWR;
            TLBFILL_OPCODE:  r.aluop = ALU_TLBFILL;
            RDCNTVHW_OPCODE: r.aluop = ALU_RDCNTVHW;
            RDCNTID_OPCODE: begin
                r.aluop = ALU_RDCNTID;
                if (rj == 5'd0) begin
                    r.aluop = ALU_RDCNTVLW;
                end
            end
            default: ;
        endcase
        if (r.aluop inside {ALU_RDCNTID, ALU_RDCNTVLW, ALU_RDCNTVHW}) begin
            r.is_cnt         = 1'b1;
            r.alusel         = ALU_SEL_CSR;
            r.reg_write_en   = 1'b1;
            r.reg_write_addr = (r.aluop == ALU_RDCNTID) ? rj : rd;
            r.csr_read_en    = (r.aluop == ALU_RDCNTID);
        end else if (r.aluop != ALU_NOP) begin
            r.is_privilege = 1'b1;
            if (r.aluop != ALU_ERTN) begin
                r.alusel = ALU_SEL_CSR; // tlb ops.
            end
        end else if (inst[31:15] inside {ADD_W_OPCODE, SUB_W_OPCODE, AND_OPCODE, OR_OPCODE}) begin
            r.reg_read_en      = 2'b11;
            r.reg_read_addr[0] = rj;
            r.reg_read_addr[1] = inst[14:10];
            r.reg_write_en     = 1'b1;
            r.reg_write_addr   = rd;
            case (inst[31:15])
                ADD_W_OPCODE: r.aluop = ALU_ADD;
                SUB_W_OPCODE: r.aluop = ALU_SUB;
                AND_OPCODE:   r.aluop = ALU_AND;
                default:      r.aluop = ALU_OR;
            endcase
            r.alusel = ALU_SEL_LOGIC;
            if (r.aluop inside {ALU_ADD, ALU_SUB}) begin
                r.alusel = ALU_SEL_ARITH;
            end
        end else if (inst[31:22] inside {ADDI_W_OPCODE, LD_W_OPCODE, ST_W_OPCODE}) begin
            r.imm              = inst[21] ? (32'hffff_f000 | 32'(inst[21:10]))
                                          : 32'(inst[21:10]);
            r.reg_read_en      = 2'b01;
            r.reg_read_addr[0] = rj;
            r.reg_write_en     = 1'b1;
            r.reg_write_addr   = rd;
            r.aluop            = ALU_LD;
            r.alusel           = ALU_SEL_LOAD_STORE;
            if (inst[31:22] == ADDI_W_OPCODE) begin
                r.aluop  = ALU_ADD;
                r.alusel = ALU_SEL_ARITH;
            end else if (inst[31:22] == ST_W_OPCODE) begin
                r.aluop            = ALU_ST;
                r.reg_read_en      = 2'b11;
                r.reg_read_addr[1] = rd; // store data.
                r.reg_write_en     = 1'b0;
                r.reg_write_addr   = 5'd0;
            end
        end else if (inst[31:24] == CSR_OPCODE) begin
            r.is_privilege     = 1'b1;
            r.alusel           = ALU_SEL_CSR;
            r.csr_addr         = inst[23:10];
            r.csr_read_en      = 1'b1;
            r.csr_write_en     = (rj != 5'd0);
            r.reg_write_en     = 1'b1;
            r.reg_write_addr   = rd;
            r.reg_read_en      = (rj == 5'd0) ? 2'b00 : ((rj == 5'd1) ? 2'b01 : 2'b11);
            r.reg_read_addr[0] = (rj == 5'd0) ? 5'd0 : rd;
            r.reg_read_addr[1] = (rj > 5'd1) ? rj : 5'd0;
            case (rj)
                5'd0:    r.aluop = ALU_CSRRD;
                5'd1:    r.aluop = ALU_CSRWR;
                default: r.aluop = ALU_CSRXCHG;
            endcase
        end else begin
            r.inst_valid      = 1'b0;
            r.is_exception    = 1'b1;
            r.exception_cause = EXC_INE;
        end
        return r;
    endfunction

    task automatic check_dispatch(input id_dispatch_t exp, input id_dispatch_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errs++;
            $display("Error: %s dispatch expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_valid(input bit exp, input bit act);
        checks++;
        if (act != exp) begin
            errors++;
            test_errs++;
            $display("Error: %s dispatch_valid expected %b actual %b", test_name, exp, act);
        end
    endtask

    task automatic send(input bus32_t inst);
        @(negedge clk);
        fetch_valid_i = 1'b1;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        fetch_pc_i    = pc_next;
        fetch_inst_i  = inst;
        exp_q.push_back(ref_decode(pc_next, inst));
        pc_next = pc_next + 32'd4;
    endtask

    // upstream keeps the word on its inputs while stalled.
    task automatic send_stalled(input bus32_t inst, input int cycles);
        send(inst);
        stall_i = 1'b1;
        repeat (cycles) @(negedge clk);
        stall_i = 1'b0;
    endtask

    task automatic idle();
        @(negedge clk);
        fetch_valid_i = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        idle();
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: test %s still waits for %0d results", test_name, exp_q.size());
            $display("Regression failed");
            $finish;
        end else begin
            idle(); // lets the hold check see the last result.
            @(posedge clk);
            $display("test %s done with %0d errors", test_name, test_errs);
        end
    endtask

    initial begin : scoreboard
        forever begin
            @(posedge clk);
            fresh    = 1'b0;
            in_reset = !arst_n_i;
            if (!arst_n_i) begin
                exp_valid = 1'b0;
            end else if (flush_i) begin
                exp_valid = 1'b0;
                if (fetch_valid_i && exp_q.size() != 0) begin
                    exp_q.delete(0); // killed in flight.
                end
            end else if (!stall_i) begin
                exp_valid = fetch_valid_i;
                fresh     = fetch_valid_i;
            end
            @(negedge clk);
            if (!in_reset) begin
                check_valid(exp_valid, dispatch_valid_o);
                if (fresh && exp_q.size() == 0) begin
                    errors++;
                    test_errs++;
                    $display("test %s dispatched a record that was never sent", test_name);
                end else if (fresh) begin
                    held = exp_q.pop_front();
                end
                check_dispatch(held, dispatch_o);
            end
        end
    end

    initial begin : stimulus
        int stall_len;
        arst_n_i      = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_inst_i  = '0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        pc_next       = 32'h1c00_0000;
        errors        = 0;
        checks        = 0;
        start_test("reset");
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        end_test();

        start_test("system");
        foreach (sys_ops[i]) begin
            send({sys_ops[i], 10'(next_rand())});
        end
        send({RDCNTID_OPCODE, 5'd0, 5'(next_rand())}); // rdcntvl.w.
        send({RDCNTID_OPCODE, 5'(next_rand()) | 5'd1, 5'(next_rand())});
        end_test();

        start_test("alu");
        repeat (2) foreach (alu_ops[i]) send({alu_ops[i], 15'(next_rand())});
        end_test();

        start_test("immediate");
        foreach (imm_ops[i]) begin
            send({imm_ops[i], 1'b1, 21'(next_rand())}); // negative imm.
            send({imm_ops[i], 1'b0, 21'(next_rand())});
        end
        end_test();

        start_test("csr");
        repeat (2) begin
            send({CSR_OPCODE, 14'(next_rand()), 5'd0, 5'(next_rand())});
            send({CSR_OPCODE, 14'(next_rand()), 5'd1, 5'(next_rand())});
            send({CSR_OPCODE, 14'(next_rand()), 5'(next_rand()) | 5'd2, 5'(next_rand())});
        end
        end_test();

        start_test("illegal");
        repeat (8) send({1'b1, 31'(next_rand())}); // bit 31 is clear in every opcode.
        send(32'h0000_0000);
        end_test();

        start_test("burst");
        repeat (3) begin
            foreach (alu_ops[i]) send({alu_ops[i], 15'(next_rand())});
            foreach (imm_ops[i]) send({imm_ops[i], 22'(next_rand())});
        end
        end_test();

        start_test("stall");
        repeat (4) begin
            stall_len = int'(next_rand() & 32'h7) + 1;
            send({alu_ops[0], 15'(next_rand())});
            send_stalled({imm_ops[1], 22'(next_rand())}, stall_len);
        end
        end_test();

        start_test("flush");
        repeat (3) begin
            send({alu_ops[2], 15'(next_rand())});
            send({CSR_OPCODE, 24'(next_rand())});
            flush_i = 1'b1;
        end
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
la_decode_pkg.sv
decoder_1r.sv
decoder_3r.sv
decoder_2ri12.sv
decoder_csr.sv
id_select.sv
id_stage.sv
tb_id_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_id_stage -f vlog.f
out=$(./obj_dir/Vtb_id_stage)
echo "$out"
echo "$out" | grep -qx "Regression passed"
